// File: Bender.yml
package:
  name: cache_subsystem

sources:
  - include_dirs:
      - include
    files:
      - hdl/cache_pkg.sv
      - hdl/tag_data_ram.sv
      - hdl/data_cache.sv
      - hdl/instr_cache.sv
      - hdl/mem_arbiter.sv
      - hdl/cache_subsystem.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_mem_model.sv
      - testbench/tb_cache_subsystem.sv

// File: cache_subsystem.f
+incdir+include
hdl/cache_pkg.sv
hdl/tag_data_ram.sv
hdl/data_cache.sv
hdl/instr_cache.sv
hdl/mem_arbiter.sv
hdl/cache_subsystem.sv
testbench/tb_mem_model.sv
testbench/tb_cache_subsystem.sv

// File: hdl/cache_pkg.sv
`default_nettype none

package cache_pkg;

  // Data side CPU request
  typedef struct packed {
    logic        sel;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wmask;
  } cpu_req_t;

  // Instruction fetch request
  typedef struct packed {
    logic        sel;
    logic [31:0] addr;
  } fetch_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
  } mem_req_t;

  // Tag and data RAM write port
  typedef struct packed {
    logic        en;
    logic [8:0]  index;
    logic [7:0]  tag;
    logic [31:0] data;
  } ram_wr_t;

  typedef enum logic [2:0] {
    DC_IDLE,
    DC_LOOKUP,
    DC_FILL_WRITE,
    DC_MEM_READ,
    DC_MEM_WRITE,
    DC_DONE
  } dcache_state_e;

  typedef enum logic [1:0] {
    IC_IDLE,
    IC_LOOKUP,
    IC_MEM_READ,
    IC_DONE
  } icache_state_e;

  typedef enum logic [1:0] {
    OWN_NONE,
    OWN_DATA,
    OWN_INSTR
  } arb_owner_e;

endpackage

`default_nettype wire

// File: hdl/cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire cache_pkg::cpu_req_t   dreq_i,
  output logic [31:0]                drdata_o,
  output logic                       dstall_o,
  input  wire cache_pkg::fetch_req_t ireq_i,
  output logic [31:0]                irdata_o,
  output logic                       istall_o,
  output cache_pkg::mem_req_t        mem_req_o,
  output logic                       mem_valid_o,
  input  wire logic                  mem_ready_i,
  input  wire logic [31:0]           mem_rdata_i
);
  import cache_pkg::*;

  mem_req_t    d_mem_req, i_mem_req;
  logic        d_mem_valid, i_mem_valid;
  logic        d_mem_ready, i_mem_ready;
  logic [31:0] d_mem_rdata, i_mem_rdata;
  ram_wr_t     d_ram_wr, i_ram_wr;
  logic [8:0]  d_ram_index, i_ram_index;
  logic [7:0]  d_ram_tag, i_ram_tag;
  logic [31:0] d_ram_data, i_ram_data;

  data_cache dcache_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (dreq_i),
    .rdata_o     (drdata_o),
    .stall_o     (dstall_o),
    .mem_req_o   (d_mem_req),
    .mem_valid_o (d_mem_valid),
    .mem_ready_i (d_mem_ready),
    .mem_rdata_i (d_mem_rdata),
    .ram_wr_o    (d_ram_wr),
    .ram_index_o (d_ram_index),
    .ram_tag_i   (d_ram_tag),
    .ram_data_i  (d_ram_data)
  );

  instr_cache icache_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (ireq_i),
    .rdata_o     (irdata_o),
    .stall_o     (istall_o),
    .mem_req_o   (i_mem_req),
    .mem_valid_o (i_mem_valid),
    .mem_ready_i (i_mem_ready),
    .mem_rdata_i (i_mem_rdata),
    .ram_wr_o    (i_ram_wr),
    .ram_index_o (i_ram_index),
    .ram_tag_i   (i_ram_tag),
    .ram_data_i  (i_ram_data)
  );

  tag_data_ram dram_inst (
    .clk_i      (clk_i),
    .wr_i       (d_ram_wr),
    .rd_index_i (d_ram_index),
    .rd_tag_o   (d_ram_tag),
    .rd_data_o  (d_ram_data)
  );

  tag_data_ram iram_inst (
    .clk_i      (clk_i),
    .wr_i       (i_ram_wr),
    .rd_index_i (i_ram_index),
    .rd_tag_o   (i_ram_tag),
    .rd_data_o  (i_ram_data)
  );

  mem_arbiter arbiter_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .d_req_i     (d_mem_req),
    .d_valid_i   (d_mem_valid),
    .d_ready_o   (d_mem_ready),
    .d_rdata_o   (d_mem_rdata),
    .i_req_i     (i_mem_req),
    .i_valid_i   (i_mem_valid),
    .i_ready_o   (i_mem_ready),
    .i_rdata_o   (i_mem_rdata),
    .rdata_i     (mem_rdata_i),
    .mem_req_o   (mem_req_o),
    .mem_valid_o (mem_valid_o),
    .mem_ready_i (mem_ready_i)
  );

endmodule

`default_nettype wire

// File: hdl/data_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module data_cache (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire cache_pkg::cpu_req_t req_i,
  output logic [31:0]              rdata_o,
  output logic                     stall_o,
  output cache_pkg::mem_req_t      mem_req_o,
  output logic                     mem_valid_o,
  input  wire logic                mem_ready_i,
  input  wire logic [31:0]         mem_rdata_i,
  output cache_pkg::ram_wr_t       ram_wr_o,
  output logic [8:0]               ram_index_o,
  input  wire logic [7:0]          ram_tag_i,
  input  wire logic [31:0]         ram_data_i
);
  import cache_pkg::*;

  dcache_state_e           state_q, state_d;
  logic [`CACHE_LINES-1:0] valid_q, valid_d;
  logic [`CACHE_LINES-1:0] dirty_q, dirty_d;
  logic [31:0]             data_q, data_d;
  logic [7:0]              victim_tag_q, victim_tag_d;

  logic [8:0]  index;
  logic [7:0]  tag;
  logic        full_word;
  logic        tag_hit;
  logic [31:0] hit_merge;
  logic [31:0] fill_merge;

  // Store data arrives right-aligned, the mask picks the lane
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  mask);
    logic [31:0] word;
    word = wdata;
    case (mask)
      4'b0001: word = {old_word[31:8], wdata[7:0]};
      4'b0010: word = {old_word[31:16], wdata[7:0], old_word[7:0]};
      4'b0100: word = {old_word[31:24], wdata[7:0], old_word[15:0]};
      4'b1000: word = {wdata[7:0], old_word[23:0]};
      4'b0011: word = {old_word[31:16], wdata[15:0]};
      4'b1100: word = {wdata[15:0], old_word[15:0]};
      default: word = wdata;
    endcase
    return word;
  endfunction

  assign index      = req_i.addr[`CACHE_IDX];
  assign tag        = req_i.addr[`CACHE_TAG];
  assign full_word  = &req_i.wmask;
  assign tag_hit    = (ram_tag_i == tag);
  assign hit_merge  = merge_bytes(ram_data_i, req_i.wdata, req_i.wmask);
  assign fill_merge = merge_bytes(mem_rdata_i, req_i.wdata, req_i.wmask);

  always_comb begin
    state_d      = state_q;
    valid_d      = valid_q;
    dirty_d      = dirty_q;
    data_d       = data_q;
    victim_tag_d = victim_tag_q;
    case (state_q)
      DC_IDLE: begin
        if (req_i.sel) begin
          if (!req_i.write) begin
            state_d = valid_q[index] ? DC_LOOKUP : DC_MEM_READ;
          end else if (valid_q[index] && dirty_q[index]) begin
            state_d = DC_LOOKUP;
          end else if (full_word) begin
            // Clean or empty line, overwrite directly
            state_d = DC_FILL_WRITE;
            data_d  = req_i.wdata;
          end else begin
            state_d = DC_MEM_READ;
          end
        end
      end
      DC_LOOKUP: begin
        if (tag_hit) begin
          state_d = req_i.write ? DC_FILL_WRITE : DC_DONE;
          data_d  = req_i.write ? hit_merge : ram_data_i;
        end else if (dirty_q[index]) begin
          // Victim goes out first
          state_d      = DC_MEM_WRITE;
          data_d       = ram_data_i;
          victim_tag_d = ram_tag_i;
        end else begin
          state_d = DC_MEM_READ;
        end
      end
      DC_MEM_WRITE: begin
        if (mem_ready_i) begin
          if (req_i.write && full_word) begin
            state_d = DC_FILL_WRITE;
            data_d  = req_i.wdata;
          end else begin
            state_d = DC_MEM_READ;
          end
        end
      end
      DC_MEM_READ: begin
        if (mem_ready_i) begin
          state_d = DC_FILL_WRITE;
          data_d  = req_i.write ? fill_merge : mem_rdata_i;
        end
      end
      DC_FILL_WRITE: begin
        state_d        = DC_DONE;
        valid_d[index] = 1'b1;
        dirty_d[index] = req_i.write;
      end
      DC_DONE: begin
        state_d = DC_IDLE;
      end
      default: begin
        state_d = DC_IDLE;
      end
    endcase
  end

  always_comb begin
    mem_req_o   = '0;
    mem_valid_o = 1'b0;
    case (state_q)
      DC_MEM_READ: begin
        mem_req_o.addr = {req_i.addr[31:2], 2'b00};
        mem_valid_o    = 1'b1;
      end
      DC_MEM_WRITE: begin
        // Rebuild the victim address from its stored tag
        mem_req_o.addr  = {`CACHE_BASE_HI, 5'b0, victim_tag_q, index, 2'b00};
        mem_req_o.wdata = data_q;
        mem_req_o.we    = 1'b1;
        mem_valid_o     = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign ram_index_o    = index;
  assign ram_wr_o.en    = (state_q == DC_FILL_WRITE);
  assign ram_wr_o.index = index;
  assign ram_wr_o.tag   = tag;
  assign ram_wr_o.data  = data_q;

  assign rdata_o = data_q;
  assign stall_o = (state_d != DC_IDLE);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= DC_IDLE;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      state_q <= state_d;
      valid_q <= valid_d;
      dirty_q <= dirty_d;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q       <= data_d;
    victim_tag_q <= victim_tag_d;
  end

endmodule

`default_nettype wire

// File: hdl/instr_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module instr_cache (
  input  wire logic                  clk_i,
  input  wire logic                  rst_i,
  input  wire cache_pkg::fetch_req_t req_i,
  output logic [31:0]                rdata_o,
  output logic                       stall_o,
  output cache_pkg::mem_req_t        mem_req_o,
  output logic                       mem_valid_o,
  input  wire logic                  mem_ready_i,
  input  wire logic [31:0]           mem_rdata_i,
  output cache_pkg::ram_wr_t         ram_wr_o,
  output logic [8:0]                 ram_index_o,
  input  wire logic [7:0]            ram_tag_i,
  input  wire logic [31:0]           ram_data_i
);
  import cache_pkg::*;

  icache_state_e           state_q, state_d;
  logic [`CACHE_LINES-1:0] valid_q;
  logic [31:0]             data_q, data_d;
  logic [8:0]              index;
  logic                    fill;

  assign index = req_i.addr[`CACHE_IDX];
  assign fill  = (state_q == IC_MEM_READ) && mem_ready_i;

  always_comb begin
    state_d = state_q;
    data_d  = data_q;
    case (state_q)
      IC_IDLE: begin
        if (req_i.sel) begin
          state_d = valid_q[index] ? IC_LOOKUP : IC_MEM_READ;
        end
      end
      IC_LOOKUP: begin
        if (ram_tag_i == req_i.addr[`CACHE_TAG]) begin
          state_d = IC_DONE;
          data_d  = ram_data_i;
        end else begin
          state_d = IC_MEM_READ;
        end
      end
      IC_MEM_READ: begin
        if (mem_ready_i) begin
          state_d = IC_DONE;
          data_d  = mem_rdata_i;
        end
      end
      default: begin
        state_d = IC_IDLE;
      end
    endcase
  end

  // Read only, never writes memory
  assign mem_req_o.addr  = {req_i.addr[31:2], 2'b00};
  assign mem_req_o.wdata = '0;
  assign mem_req_o.we    = 1'b0;
  assign mem_valid_o     = (state_q == IC_MEM_READ);

  // Fill the RAM in the same cycle the word returns
  assign ram_index_o    = index;
  assign ram_wr_o.en    = fill;
  assign ram_wr_o.index = index;
  assign ram_wr_o.tag   = req_i.addr[`CACHE_TAG];
  assign ram_wr_o.data  = mem_rdata_i;

  assign rdata_o = data_q;
  assign stall_o = (state_d != IC_IDLE);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IC_IDLE;
      valid_q <= '0;
    end else begin
      state_q <= state_d;
      if (fill) begin
        valid_q[index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
  end

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire cache_pkg::mem_req_t d_req_i,
  input  wire logic                d_valid_i,
  output logic                     d_ready_o,
  output logic [31:0]              d_rdata_o,
  input  wire cache_pkg::mem_req_t i_req_i,
  input  wire logic                i_valid_i,
  output logic                     i_ready_o,
  output logic [31:0]              i_rdata_o,
  input  wire logic [31:0]         rdata_i,
  output cache_pkg::mem_req_t      mem_req_o,
  output logic                     mem_valid_o,
  input  wire logic                mem_ready_i
);
  import cache_pkg::*;

  arb_owner_e owner_q;
  arb_owner_e grant;
  logic       last_data_q;

  // Data first, but instruction side goes next after a data transfer
  always_comb begin
    grant = owner_q;
    if (owner_q == OWN_NONE) begin
      if (d_valid_i && (!i_valid_i || !last_data_q)) begin
        grant = OWN_DATA;
      end else if (i_valid_i) begin
        grant = OWN_INSTR;
      end
    end
  end

  always_comb begin
    mem_req_o   = '0;
    mem_valid_o = 1'b0;
    case (grant)
      OWN_DATA: begin
        mem_req_o   = d_req_i;
        mem_valid_o = d_valid_i;
      end
      OWN_INSTR: begin
        mem_req_o   = i_req_i;
        mem_valid_o = i_valid_i;
      end
      default: begin
      end
    endcase
  end

  assign d_ready_o = (grant == OWN_DATA) && mem_ready_i;
  assign i_ready_o = (grant == OWN_INSTR) && mem_ready_i;
  assign d_rdata_o = (grant == OWN_DATA) ? rdata_i : '0;
  assign i_rdata_o = (grant == OWN_INSTR) ? rdata_i : '0;

  // Ownership held until the ready pulse
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      owner_q     <= OWN_NONE;
      last_data_q <= 1'b0;
    end else begin
      owner_q <= mem_ready_i ? OWN_NONE : grant;
      if (mem_ready_i && (grant != OWN_NONE)) begin
        last_data_q <= (grant == OWN_DATA);
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/tag_data_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_cfg.svh"

module tag_data_ram (
  input  wire logic               clk_i,
  input  wire cache_pkg::ram_wr_t wr_i,
  input  wire logic [8:0]         rd_index_i,
  output logic [7:0]              rd_tag_o,
  output logic [31:0]             rd_data_o
);

  // Tag sits in the upper byte of an entry
  logic [39:0] entries [`CACHE_LINES];

  always_ff @(posedge clk_i) begin
    if (wr_i.en) begin
      entries[wr_i.index] <= {wr_i.tag, wr_i.data};
    end
  end

  // Registered read, data one cycle after the index
  always_ff @(posedge clk_i) begin
    {rd_tag_o, rd_data_o} <= entries[rd_index_i];
  end

endmodule

`default_nettype wire

// File: include/cache_cfg.svh
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

// Lines per direct-mapped cache
`define CACHE_LINES 512

// Byte address split
`define CACHE_IDX 10:2
`define CACHE_TAG 18:11

// Upper address byte of the cached window
`define CACHE_BASE_HI 8'h40

`endif

// File: testbench/tb_cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_subsystem;
  import cache_pkg::*;

  localparam int NUM_ACCESSES = 13;
  localparam int MAX_CYCLES   = 20 * NUM_ACCESSES * 12;

  // Address = {8'h40, 5'b0, tag, index, 2'b00}
  localparam logic [31:0] ADDR_A = {8'h40, 5'd0, 8'h01, 9'h010, 2'b00};
  localparam logic [31:0] ADDR_B = {8'h40, 5'd0, 8'h02, 9'h020, 2'b00};
  localparam logic [31:0] ADDR_C = {8'h40, 5'd0, 8'h03, 9'h030, 2'b00};
  localparam logic [31:0] ADDR_D = {8'h40, 5'd0, 8'h03, 9'h031, 2'b00};
  localparam logic [31:0] ADDR_E = {8'h40, 5'd0, 8'h07, 9'h020, 2'b00};
  localparam logic [31:0] ADDR_F = {8'h40, 5'd0, 8'h05, 9'h050, 2'b00};
  localparam logic [31:0] ADDR_G = {8'h40, 5'd0, 8'h06, 9'h060, 2'b00};

  logic        clk_i;
  logic        rst_i;
  cpu_req_t    dreq;
  fetch_req_t  ireq;
  logic [31:0] drdata, irdata, mem_rdata;
  logic        dstall, istall, mem_valid, mem_ready;
  mem_req_t    mem_req, held_req, d_held_req, i_held_req;

  int    errors, tests, err_at_start, cycles;
  int    transfers, valid_cycles, mem_writes, d_xfers, i_xfers;
  logic  wait_q, d_wait_q, i_wait_q;
  logic [31:0] last_wr_addr, last_wr_data;
  string test_name;

  cache_subsystem cache_subsystem_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .dreq_i      (dreq),
    .drdata_o    (drdata),
    .dstall_o    (dstall),
    .ireq_i      (ireq),
    .irdata_o    (irdata),
    .istall_o    (istall),
    .mem_req_o   (mem_req),
    .mem_valid_o (mem_valid),
    .mem_ready_i (mem_ready),
    .mem_rdata_i (mem_rdata)
  );

  tb_mem_model mem_model_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (mem_req),
    .valid_i (mem_valid),
    .ready_o (mem_ready),
    .rdata_o (mem_rdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles, an access never finished", cycles);
      $display("Test FAILED");
      $finish;
    end
  end

  // Memory port protocol and transfer bookkeeping
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (wait_q) begin
        assert (mem_valid && mem_req === held_req) else begin
          $display("Memory request dropped or changed while waiting for ready");
          errors = errors + 1;
        end
      end
      // Each cache keeps its request up until its own ready
      if (d_wait_q) begin
        assert (cache_subsystem_inst.d_mem_valid
                && cache_subsystem_inst.d_mem_req === d_held_req) else begin
          $display("Data cache dropped or changed its memory request before ready");
          errors = errors + 1;
        end
      end
      if (i_wait_q) begin
        assert (cache_subsystem_inst.i_mem_valid
                && cache_subsystem_inst.i_mem_req === i_held_req) else begin
          $display("Instruction cache dropped or changed its memory request before ready");
          errors = errors + 1;
        end
      end
      if (mem_valid) begin
        valid_cycles = valid_cycles + 1;
        assert ((cache_subsystem_inst.d_mem_valid && mem_req === cache_subsystem_inst.d_mem_req)
             || (cache_subsystem_inst.i_mem_valid && mem_req === cache_subsystem_inst.i_mem_req))
        else begin
          $display("Memory port carries a request that no waiting cache made");
          errors = errors + 1;
        end
      end
      if (mem_valid && mem_ready) begin
        transfers = transfers + 1;
        if (mem_req.we) begin
          mem_writes   = mem_writes + 1;
          last_wr_addr = mem_req.addr;
          last_wr_data = mem_req.wdata;
        end
      end
      if (cache_subsystem_inst.d_mem_ready) begin
        d_xfers = d_xfers + 1;
      end
      if (cache_subsystem_inst.i_mem_ready) begin
        i_xfers = i_xfers + 1;
      end
      wait_q     = mem_valid && !mem_ready;
      held_req   = mem_req;
      d_wait_q   = cache_subsystem_inst.d_mem_valid && !cache_subsystem_inst.d_mem_ready;
      d_held_req = cache_subsystem_inst.d_mem_req;
      i_wait_q   = cache_subsystem_inst.i_mem_valid && !cache_subsystem_inst.i_mem_ready;
      i_held_req = cache_subsystem_inst.i_mem_req;
    end
  end

  // Store data is right-aligned and lands at the lowest enabled lane
  function automatic logic [31:0] lane_merge(input logic [31:0] old_word,
                                             input logic [31:0] wdata,
                                             input logic [3:0]  mask);
    logic [31:0] shifted;
    logic [31:0] result;
    int          low;
    int          k;
    low = 0;
    while (low < 3 && !mask[low]) begin
      low = low + 1;
    end
    shifted = wdata << (8 * low);
    result  = old_word;
    for (k = 0; k < 4; k = k + 1) begin
      if (mask[k]) begin
        result[8*k +: 8] = shifted[8*k +: 8];
      end
    end
    return result;
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error %s (%s): expected 0x%08h, actual 0x%08h",
               test_name, what, expected, actual);
      errors = errors + 1;
    end
  endtask

  task automatic begin_test(input string name);
    test_name    = name;
    err_at_start = errors;
  endtask

  task automatic end_test();
    tests = tests + 1;
    if (errors == err_at_start) begin
      $display("%-22s passed", test_name);
    end else begin
      $display("%-22s failed with %0d errors", test_name, errors - err_at_start);
    end
  endtask

  // Called and returns 1 ns after a rising edge
  task automatic data_access(input logic write, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] wmask,
                             output logic [31:0] rdata, output int stalls);
    dreq.sel   = 1'b1;
    dreq.write = write;
    dreq.addr  = addr;
    dreq.wdata = wdata;
    dreq.wmask = wmask;
    stalls     = 0;
    @(negedge clk_i);
    while (dstall) begin
      stalls = stalls + 1;
      @(negedge clk_i);
    end
    rdata = drdata;
    @(posedge clk_i);
    #1;
    dreq = '0;
  endtask

  task automatic fetch_access(input logic [31:0] addr, output logic [31:0] rdata,
                              output int stalls);
    ireq.sel  = 1'b1;
    ireq.addr = addr;
    stalls    = 0;
    @(negedge clk_i);
    while (istall) begin
      stalls = stalls + 1;
      @(negedge clk_i);
    end
    rdata = irdata;
    @(posedge clk_i);
    #1;
    ireq = '0;
  endtask

  initial begin
    logic [31:0] rdata;
    logic [31:0] idata;
    logic [31:0] expected;
    int          stalls;
    int          istalls;
    int          count_before;
    int          i_before;

    errors = 0;
    tests = 0;
    cycles = 0;
    transfers = 0;
    valid_cycles = 0;
    mem_writes = 0;
    d_xfers = 0;
    i_xfers = 0;
    wait_q = 1'b0;
    d_wait_q = 1'b0;
    i_wait_q = 1'b0;
    rst_i = 1'b1;
    dreq = '0;
    ireq = '0;
    repeat (16) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    begin_test("after_reset");
    @(negedge clk_i);
    assert (!dstall && !istall && !mem_valid) else begin
      $display("Stall or memory valid is high right after reset");
      errors = errors + 1;
    end
    @(posedge clk_i);
    #1;
    end_test();

    begin_test("read_miss_then_hit");
    expected = mem_model_inst.word_at(ADDR_A);
    data_access(1'b0, ADDR_A, '0, 4'b0000, rdata, stalls);
    check_value("miss data", expected, rdata);
    count_before = valid_cycles;
    data_access(1'b0, ADDR_A, '0, 4'b0000, rdata, stalls);
    check_value("hit data", expected, rdata);
    check_value("hit stall cycles", 2, stalls);
    check_value("hit memory valid cycles", count_before, valid_cycles);
    end_test();

    begin_test("full_word_write");
    count_before = valid_cycles;
    data_access(1'b1, ADDR_B, 32'hcafe_0b0b, 4'b1111, rdata, stalls);
    check_value("write stall cycles", 2, stalls);
    data_access(1'b0, ADDR_B, '0, 4'b0000, rdata, stalls);
    check_value("read after write", 32'hcafe_0b0b, rdata);
    check_value("memory valid cycles", count_before, valid_cycles);
    end_test();

    begin_test("partial_writes");
    expected = lane_merge(mem_model_inst.word_at(ADDR_C), 32'h0000_00a7, 4'b0010);
    data_access(1'b1, ADDR_C, 32'h0000_00a7, 4'b0010, rdata, stalls);
    data_access(1'b0, ADDR_C, '0, 4'b0000, rdata, stalls);
    check_value("byte merge", expected, rdata);
    expected = lane_merge(mem_model_inst.word_at(ADDR_D), 32'h0000_beef, 4'b1100);
    data_access(1'b1, ADDR_D, 32'h0000_beef, 4'b1100, rdata, stalls);
    data_access(1'b0, ADDR_D, '0, 4'b0000, rdata, stalls);
    check_value("halfword merge", expected, rdata);
    end_test();

    // Same index as the dirty line at ADDR_B
    begin_test("dirty_eviction");
    count_before = mem_writes;
    data_access(1'b1, ADDR_E, 32'h1234_5678, 4'b1111, rdata, stalls);
    check_value("memory writes", count_before + 1, mem_writes);
    check_value("victim address", ADDR_B, last_wr_addr);
    check_value("victim data", 32'hcafe_0b0b, last_wr_data);
    check_value("memory after eviction", 32'hcafe_0b0b, mem_model_inst.word_at(ADDR_B));
    data_access(1'b0, ADDR_B, '0, 4'b0000, rdata, stalls);
    check_value("evicted word read back", 32'hcafe_0b0b, rdata);
    check_value("second victim in memory", 32'h1234_5678, mem_model_inst.word_at(ADDR_E));
    end_test();

    begin_test("simultaneous_misses");
    count_before = d_xfers;
    i_before     = i_xfers;
    fork
      data_access(1'b0, ADDR_F, '0, 4'b0000, rdata, stalls);
      fetch_access(ADDR_G, idata, istalls);
    join
    check_value("data miss", mem_model_inst.word_at(ADDR_F), rdata);
    check_value("fetch miss", mem_model_inst.word_at(ADDR_G), idata);
    check_value("data transfers", count_before + 1, d_xfers);
    check_value("fetch transfers", i_before + 1, i_xfers);
    fetch_access(ADDR_G, idata, istalls);
    check_value("fetch hit", mem_model_inst.word_at(ADDR_G), idata);
    check_value("fetch hit stall cycles", 2, istalls);
    end_test();

    $display("%0d tests run, %0d memory transfers, %0d errors", tests, transfers, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire cache_pkg::mem_req_t req_i,
  input  wire logic                valid_i,
  output logic                     ready_o,
  output logic [31:0]              rdata_o
);

  // Sparse store, only written words are kept
  logic [31:0] words [logic [31:0]];
  logic        busy;
  int unsigned wait_cnt;

  // Unwritten words follow a pattern of the full address
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    if (words.exists(addr)) begin
      return words[addr];
    end
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
  endfunction

  initial begin
    void'($urandom(32'h8c57));
    ready_o  = 1'b0;
    rdata_o  = '0;
    busy     = 1'b0;
    wait_cnt = 0;
    forever begin
      @(posedge clk_i);
      #1;
      ready_o = 1'b0;
      rdata_o = '0;
      if (rst_i) begin
        busy = 1'b0;
      end else if (busy) begin
        if (wait_cnt == 0) begin
          busy    = 1'b0;
          ready_o = 1'b1;
          if (req_i.we) begin
            words[req_i.addr] = req_i.wdata;
          end else begin
            rdata_o = word_at(req_i.addr);
          end
        end else begin
          wait_cnt = wait_cnt - 1;
        end
      end else if (valid_i) begin
        // Ready follows 1 to 4 cycles after valid
        busy     = 1'b1;
        wait_cnt = $urandom_range(3, 0);
      end
    end
  end

endmodule

`default_nettype wire
